//--- Bender.yml
package:
  name: r22_fft16

sources:
  - files:
      - logic/fft_types_pkg.sv
      - logic/twiddle_pkg.sv
      - logic/delay_fifo.sv
      - logic/bf2_first.sv
      - logic/bf2_second.sv
      - logic/twiddle_mult.sv
      - logic/r22_fft16.sv
  - target: test
    files:
      - tests/r22_fft16_assertions.sv
      - tests/r22_fft16_tb.sv

//--- build.f
logic/fft_types_pkg.sv
logic/twiddle_pkg.sv
logic/delay_fifo.sv
logic/bf2_first.sv
logic/bf2_second.sv
logic/twiddle_mult.sv
logic/r22_fft16.sv
tests/r22_fft16_assertions.sv
tests/r22_fft16_tb.sv

//--- logic/bf2_first.sv
`timescale 1ns/10ps

module bf2_first #(
    parameter int width = 12,
    parameter int delay = 8
)
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     in_valid,
    input  fft_types_pkg::bf_phase_e phase,
    input  logic signed [width-1:0]  x_re,
    input  logic signed [width-1:0]  x_im,
    output logic signed [width:0]    y_re,
    output logic signed [width:0]    y_im
);

    // One bit of growth per butterfly
    localparam int out_width = width + 1;
    localparam int cnt_width = $clog2(delay) + 1;

    logic signed [out_width-1:0]   x_re_ext;
    logic signed [out_width-1:0]   x_im_ext;
    logic signed [out_width-1:0]   d_re;
    logic signed [out_width-1:0]   d_im;
    logic signed [out_width-1:0]   w_re;
    logic signed [out_width-1:0]   w_im;
    logic signed [2*out_width-1:0] fifo_wdata;
    logic signed [2*out_width-1:0] fifo_rdata;
    logic [cnt_width-1:0]          fifo_level;
    logic                          fifo_rd;

    // Sign extend the new sample to the stored width
    assign x_re_ext = out_width'(x_re);
    assign x_im_ext = out_width'(x_im);

    // Real part packed above imaginary part in the delay line
    assign {d_re, d_im} = fifo_rdata;
    assign fifo_wdata   = {w_re, w_im};

    // The read register is the last slot of the delay
    // So memory settles one word short of the full delay
    assign fifo_rd = in_valid && (fifo_level == cnt_width'(delay - 1));

    always_comb
    begin
        if (phase == fft_types_pkg::BF_COMBINE)
        begin
            // d here is the raw sample from delay samples back
            y_re = d_re + x_re_ext;
            y_im = d_im + x_im_ext;
            w_re = d_re - x_re_ext;
            w_im = d_im - x_im_ext;
        end
        else
        begin
            // Drain the differences left by the previous combine half
            y_re = d_re;
            y_im = d_im;
            w_re = x_re_ext;
            w_im = x_im_ext;
        end
    end

    // Feedback delay, one write per accepted sample
    delay_fifo #(
        .data_width (2 * out_width),
        .depth      (delay)
    ) u_delay (
        .clk          (clk),
        .rst_n        (rst_n),
        .wr_en        (in_valid),
        .rd_en        (fifo_rd),
        .fifo_in      (fifo_wdata),
        .fifo_out     (fifo_rdata),
        .empty        (),
        .full         (),
        .fifo_counter (fifo_level)
    );

endmodule

//--- logic/bf2_second.sv
`timescale 1ns/10ps

module bf2_second #(
    parameter int width = 13,
    parameter int delay = 4
)
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     in_valid,
    input  fft_types_pkg::bf_phase_e phase,
    input  logic                     rot_neg_j,
    input  logic signed [width-1:0]  x_re,
    input  logic signed [width-1:0]  x_im,
    output logic signed [width:0]    y_re,
    output logic signed [width:0]    y_im
);

    localparam int out_width = width + 1;
    localparam int cnt_width = $clog2(delay) + 1;

    logic signed [out_width-1:0]   x_re_ext;
    logic signed [out_width-1:0]   x_im_ext;
    logic signed [out_width-1:0]   s_re;
    logic signed [out_width-1:0]   s_im;
    logic signed [out_width-1:0]   d_re;
    logic signed [out_width-1:0]   d_im;
    logic signed [out_width-1:0]   w_re;
    logic signed [out_width-1:0]   w_im;
    logic signed [2*out_width-1:0] fifo_wdata;
    logic signed [2*out_width-1:0] fifo_rdata;
    logic [cnt_width-1:0]          fifo_level;
    logic                          fifo_rd;
    logic                          combine;

    assign x_re_ext = out_width'(x_re);
    assign x_im_ext = out_width'(x_im);
    assign combine  = (phase == fft_types_pkg::BF_COMBINE);

    ////////////////////
    // Trivial multiply by -j

    // (a + jb)(-j) = b - ja
    // Negation is done at the wider width so the most negative input cannot wrap
    always_comb
    begin
        if (combine && rot_neg_j)
        begin
            s_re = x_im_ext;
            s_im = -x_re_ext;
        end
        else
        begin
            s_re = x_re_ext;
            s_im = x_im_ext;
        end
    end

    ////////////////////
    // Butterfly

    assign {d_re, d_im} = fifo_rdata;
    assign fifo_wdata   = {w_re, w_im};

    // Same priming rule as the first-type butterfly
    assign fifo_rd = in_valid && (fifo_level == cnt_width'(delay - 1));

    always_comb
    begin
        if (combine)
        begin
            y_re = d_re + s_re;
            y_im = d_im + s_im;
            w_re = d_re - s_re;
            w_im = d_im - s_im;
        end
        else
        begin
            y_re = d_re;
            y_im = d_im;
            w_re = s_re;
            w_im = s_im;
        end
    end

    delay_fifo #(
        .data_width (2 * out_width),
        .depth      (delay)
    ) u_delay (
        .clk          (clk),
        .rst_n        (rst_n),
        .wr_en        (in_valid),
        .rd_en        (fifo_rd),
        .fifo_in      (fifo_wdata),
        .fifo_out     (fifo_rdata),
        .empty        (),
        .full         (),
        .fifo_counter (fifo_level)
    );

endmodule

//--- logic/delay_fifo.sv
`timescale 1ns/10ps

module delay_fifo #(
    parameter int data_width = 16,
    parameter int depth      = 8
)
(
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         wr_en,
    input  logic                         rd_en,
    input  logic signed [data_width-1:0] fifo_in,
    output logic signed [data_width-1:0] fifo_out,
    output logic                         empty,
    output logic                         full,
    output logic [$clog2(depth):0]       fifo_counter
);

    // Counter holds 0..depth, pointers need at least one bit
    localparam int cnt_width = $clog2(depth) + 1;
    localparam int ptr_width = (depth > 1) ? $clog2(depth) : 1;

    logic signed [data_width-1:0] fifo_mem [depth];
    logic [ptr_width-1:0]         rd_ptr;
    logic [ptr_width-1:0]         wr_ptr;
    logic                         pass_through;
    logic                         do_write;
    logic                         do_read;

    assign empty = (fifo_counter == '0);
    assign full  = (fifo_counter == cnt_width'(depth));

    // Read and write together on an empty FIFO
    // Word goes straight to the output register and memory is left alone
    assign pass_through = empty && wr_en && rd_en;
    assign do_write     = wr_en && !full && !pass_through;
    assign do_read      = rd_en && !empty;

    ////////////////////
    // Occupancy

    always_ff @(posedge clk or posedge rst_n)
    begin
        if (rst_n)
            fifo_counter <= '0;
        else if (do_write && !do_read)
            fifo_counter <= fifo_counter + 1'b1;
        else if (do_read && !do_write)
            fifo_counter <= fifo_counter - 1'b1;
    end

    ////////////////////
    // Circular pointers

    always_ff @(posedge clk or posedge rst_n)
    begin
        if (rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            // Explicit wrap at depth-1
            if (do_write)
                wr_ptr <= (wr_ptr == ptr_width'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_read)
                rd_ptr <= (rd_ptr == ptr_width'(depth - 1)) ? '0 : rd_ptr + 1'b1;
        end
    end

    // Storage array
    always_ff @(posedge clk)
    begin
        if (do_write)
            fifo_mem[wr_ptr] <= fifo_in;
    end

    // Registered read port
    // Holds its value between reads
    always_ff @(posedge clk or posedge rst_n)
    begin
        if (rst_n)
            fifo_out <= '0;
        else if (do_read)
            fifo_out <= fifo_mem[rd_ptr];
        else if (pass_through)
            fifo_out <= fifo_in;
    end

endmodule

//--- logic/fft_types_pkg.sv
package fft_types_pkg;

    // Transform length
    // The twiddle table only covers 16 points, so this is not a free knob
    localparam int FFT_N = 16;

    // Width of the sample counter
    // Also the number of radix-2 butterflies in the chain
    localparam int FFT_LOG_N = 4;

    // Butterfly phase, taken from one bit of a stage's aligned counter
    // Low half of each block fills the delay, high half combines
    typedef enum logic {
        // New sample into the delay line
        // Oldest stored value goes out
        BF_FILL    = 1'b0,
        // Sum of stored and new sample goes out
        // Difference goes back into the delay line
        BF_COMBINE = 1'b1
    } bf_phase_e;

endpackage

//--- logic/r22_fft16.sv
`timescale 1ns/10ps

module r22_fft16 #(
    parameter int in_width = 12
)
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       in_valid,
    input  logic signed [in_width-1:0] in_re,
    input  logic signed [in_width-1:0] in_im,
    output logic                       out_valid,
    output logic signed [in_width+3:0] out_re,
    output logic signed [in_width+3:0] out_im
);

    localparam int cw = fft_types_pkg::FFT_LOG_N;

    logic [cw-1:0]  cnt;
    logic [cw-1:0]  cnt_b2;
    logic [cw-1:0]  cnt_tw;
    logic [cw-1:0]  cnt_b3;
    logic [cw-1:0]  cnt_b4;
    logic           primed;

    fft_types_pkg::bf_phase_e phase_b1;
    fft_types_pkg::bf_phase_e phase_b2;
    fft_types_pkg::bf_phase_e phase_b3;
    fft_types_pkg::bf_phase_e phase_b4;
    logic                     rot_b2;
    logic                     rot_b4;
    logic [cw-1:0]            tw_exp;

    logic signed [in_width:0]   s1_re;
    logic signed [in_width:0]   s1_im;
    logic signed [in_width+1:0] s2_re;
    logic signed [in_width+1:0] s2_im;
    logic signed [in_width+1:0] st_re;
    logic signed [in_width+1:0] st_im;
    logic signed [in_width+2:0] s3_re;
    logic signed [in_width+2:0] s3_im;
    logic signed [in_width+3:0] s4_re;
    logic signed [in_width+3:0] s4_im;

    ////////////////////
    // Sample counter and priming

    always_ff @(posedge clk or posedge rst_n)
    begin
        if (rst_n)
        begin
            cnt    <= '0;
            primed <= 1'b0;
        end
        else if (in_valid)
        begin
            cnt <= cnt + 1'b1;
            // First full frame is in after sample 15
            if (cnt == cw'(fft_types_pkg::FFT_N - 1))
                primed <= 1'b1;
        end
    end

    ////////////////////
    // Per-stage aligned counters

    // bf1 output appears 8 samples into its block
    assign cnt_b2 = cnt + cw'(8);
    // bf2 drains 4 more samples later
    assign cnt_tw = cnt + cw'(4);

    // Follows the twiddle register, reset to its aligned value cnt+3
    always_ff @(posedge clk or posedge rst_n)
    begin
        if (rst_n)
            cnt_b3 <= cw'(3);
        else if (in_valid)
            cnt_b3 <= cnt_tw;
    end

    assign cnt_b4 = cnt_b3 - cw'(2);

    // Phase bits step down one per butterfly
    assign phase_b1 = fft_types_pkg::bf_phase_e'(cnt[3]);
    assign phase_b2 = fft_types_pkg::bf_phase_e'(cnt_b2[2]);
    assign phase_b3 = fft_types_pkg::bf_phase_e'(cnt_b3[1]);
    assign phase_b4 = fft_types_pkg::bf_phase_e'(cnt_b4[0]);

    // -j on the odd half of the difference branch
    assign rot_b2 = cnt_b2[3] & cnt_b2[2];
    assign rot_b4 = cnt_b4[1] & cnt_b4[0];

    // (c mod 4) times bit-reversed (c div 4)
    assign tw_exp = {2'b00, cnt_tw[1:0]} * {2'b00, cnt_tw[2], cnt_tw[3]};

    ////////////////////
    // Butterfly chain

    bf2_first #(
        .width (in_width),
        .delay (fft_types_pkg::FFT_N / 2)
    ) u_bf1 (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .phase    (phase_b1),
        .x_re     (in_re),
        .x_im     (in_im),
        .y_re     (s1_re),
        .y_im     (s1_im)
    );

    bf2_second #(
        .width (in_width + 1),
        .delay (fft_types_pkg::FFT_N / 4)
    ) u_bf2 (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .phase     (phase_b2),
        .rot_neg_j (rot_b2),
        .x_re      (s1_re),
        .x_im      (s1_im),
        .y_re      (s2_re),
        .y_im      (s2_im)
    );

    twiddle_mult #(
        .width (in_width + 2)
    ) u_twid (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .exponent (tw_exp),
        .x_re     (s2_re),
        .x_im     (s2_im),
        .y_re     (st_re),
        .y_im     (st_im)
    );

    bf2_first #(
        .width (in_width + 2),
        .delay (fft_types_pkg::FFT_N / 8)
    ) u_bf3 (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .phase    (phase_b3),
        .x_re     (st_re),
        .x_im     (st_im),
        .y_re     (s3_re),
        .y_im     (s3_im)
    );

    bf2_second #(
        .width (in_width + 3),
        .delay (fft_types_pkg::FFT_N / 16)
    ) u_bf4 (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .phase     (phase_b4),
        .rot_neg_j (rot_b4),
        .x_re      (s3_re),
        .x_im      (s3_im),
        .y_re      (s4_re),
        .y_im      (s4_im)
    );

    ////////////////////
    // Output register

    // Bins leave in bit-reversed order
    always_ff @(posedge clk)
    begin
        if (in_valid)
        begin
            out_re <= s4_re;
            out_im <= s4_im;
        end
    end

    always_ff @(posedge clk or posedge rst_n)
    begin
        if (rst_n)
            out_valid <= 1'b0;
        else
            out_valid <= in_valid && primed;
    end

endmodule

//--- logic/twiddle_mult.sv
`timescale 1ns/10ps

module twiddle_mult #(
    parameter int width = 14
)
(
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  in_valid,
    input  logic [fft_types_pkg::FFT_LOG_N-1:0]   exponent,
    input  logic signed [width-1:0]               x_re,
    input  logic signed [width-1:0]               x_im,
    output logic signed [width-1:0]               y_re,
    output logic signed [width-1:0]               y_im
);

    // Full product plus one bit for the sum of two products
    localparam int prod_width = width + twiddle_pkg::TW_WIDTH + 1;
    localparam logic signed [prod_width-1:0] half_lsb =
        prod_width'(1) <<< (twiddle_pkg::TW_FRAC - 1);

    logic signed [twiddle_pkg::TW_WIDTH-1:0] w_re;
    logic signed [twiddle_pkg::TW_WIDTH-1:0] w_im;
    logic signed [prod_width-1:0]            acc_re;
    logic signed [prod_width-1:0]            acc_im;

    // Clip back to the data width
    // A 45 degree rotation can push one part up by sqrt(2)
    function automatic logic signed [width-1:0] clip(input logic signed [prod_width-1:0] v);
        logic [prod_width-width:0] upper;
        upper = v[prod_width-1:width-1];
        if (upper == '0 || upper == '1)
            clip = v[width-1:0];
        else
            clip = {v[prod_width-1], {(width-1){~v[prod_width-1]}}};
    endfunction

    assign {w_re, w_im} = twiddle_pkg::tw_lookup(exponent);

    // (xr + j xi)(wr + j wi) with half an LSB added before the shift
    assign acc_re = x_re * w_re - x_im * w_im + half_lsb;
    assign acc_im = x_re * w_im + x_im * w_re + half_lsb;

    always_ff @(posedge clk or posedge rst_n)
    begin
        if (rst_n)
        begin
            y_re <= '0;
            y_im <= '0;
        end
        else if (in_valid)
        begin
            y_re <= clip(acc_re >>> twiddle_pkg::TW_FRAC);
            y_im <= clip(acc_im >>> twiddle_pkg::TW_FRAC);
        end
    end

endmodule

//--- logic/twiddle_pkg.sv
package twiddle_pkg;

    // Signed twiddle word in Q1.14
    localparam int TW_WIDTH = 16;

    // Fraction bits dropped after the multiply
    localparam int TW_FRAC = 14;

    // Real part of W16^e, cos(2*pi*e/16) scaled by 2^14 and rounded
    localparam logic signed [TW_WIDTH-1:0] TW_RE [16] = '{
        16384,  15137,  11585,   6270,
            0,  -6270, -11585, -15137,
       -16384, -15137, -11585,  -6270,
            0,   6270,  11585,  15137
    };

    // Imaginary part of W16^e, -sin(2*pi*e/16) scaled by 2^14 and rounded
    localparam logic signed [TW_WIDTH-1:0] TW_IM [16] = '{
            0,  -6270, -11585, -15137,
       -16384, -15137, -11585,  -6270,
            0,   6270,  11585,  15137,
        16384,  15137,  11585,   6270
    };

    // Twiddle for exponent 0..15
    // Real part in the upper word, imaginary part in the lower word
    function automatic logic [2*TW_WIDTH-1:0] tw_lookup(input logic [3:0] exponent);
        return {TW_RE[exponent], TW_IM[exponent]};
    endfunction

endpackage

//--- tests/r22_fft16_assertions.sv
`timescale 1ns/10ps

module r22_fft16_assertions #(
    parameter int depth = 8
)
(
    input logic                   clk,
    input logic                   rst_n,
    input logic                   wr_en,
    input logic                   empty,
    input logic                   full,
    input logic [$clog2(depth):0] fifo_counter
);

    // Count of assertion failures in this FIFO instance
    int unsigned fail_count = 0;

    ////////////////////
    // Occupancy flags

    // Empty and full never show together
    empty_full_exclusive: assert property (
        @(posedge clk) disable iff (rst_n) !(empty && full)
    )
    else
    begin
        $error("FIFO reports empty and full together");
        fail_count++;
    end

    // The delay line never sees a write while full
    no_write_when_full: assert property (
        @(posedge clk) disable iff (rst_n) wr_en |-> !full
    )
    else
    begin
        $error("FIFO write while full");
        fail_count++;
    end

    // Occupancy stays within the delay depth
    occupancy_in_range: assert property (
        @(posedge clk) disable iff (rst_n) fifo_counter <= depth
    )
    else
    begin
        $error("FIFO occupancy %0d above depth %0d", fifo_counter, depth);
        fail_count++;
    end

endmodule

//--- tests/r22_fft16_tb.sv
`timescale 1ns/10ps

module r22_fft16_tb;

    localparam int  in_w         = 12;
    localparam int  out_w        = in_w + 4;
    localparam int  n            = fft_types_pkg::FFT_N;
    localparam int  burst_frames = 20;
    localparam int  gap_frames   = 6;
    localparam int  tol          = 4;
    localparam int  reset_cycles = 2;
    localparam int  impulse_amp  = 1500;
    localparam real pi           = 3.14159265358979;

    logic                    clk;
    logic                    rst_n;
    logic                    in_valid;
    logic signed [in_w-1:0]  in_re;
    logic signed [in_w-1:0]  in_im;
    logic                    out_valid;
    logic signed [out_w-1:0] out_re;
    logic signed [out_w-1:0] out_im;

    // Stimulus for each cycle after reset
    logic stim_valid [$];
    int   stim_re [$];
    int   stim_im [$];

    // Expected bins in the order the DUT sends them
    real exp_re [$];
    real exp_im [$];

    int   cycle_count;
    int   cycle_limit = 0;
    int   accepted;
    int   last_index;
    logic last_valid;

    r22_fft16 #(
        .in_width (in_w)
    ) u_r22_fft16 (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_re     (in_re),
        .in_im     (in_im),
        .out_valid (out_valid),
        .out_re    (out_re),
        .out_im    (out_im)
    );

    // FIFO checks on every butterfly delay line
    bind delay_fifo r22_fft16_assertions #(
        .depth (depth)
    ) u_fifo_checks (
        .clk          (clk),
        .rst_n        (rst_n),
        .wr_en        (wr_en),
        .empty        (empty),
        .full         (full),
        .fifo_counter (fifo_counter)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #50 clk = ~clk;
    end

    ////////////////////
    // Helpers

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    // 4-bit bit reversal maps an output position to its bin
    function automatic int bit_reverse(input int m);
        return {m[0], m[1], m[2], m[3]};
    endfunction

    // Uniform in [-amplitude, amplitude-1]
    function automatic int random_sample(input int amplitude);
        return int'($urandom_range(2 * amplitude - 1, 0)) - amplitude;
    endfunction

    function automatic int assertion_failures();
        return u_r22_fft16.u_bf1.u_delay.u_fifo_checks.fail_count
             + u_r22_fft16.u_bf2.u_delay.u_fifo_checks.fail_count
             + u_r22_fft16.u_bf3.u_delay.u_fifo_checks.fail_count
             + u_r22_fft16.u_bf4.u_delay.u_fifo_checks.fail_count;
    endfunction

    task automatic compare_bin(input string name, input logic signed [out_w-1:0] got,
                               input real expected);
        int want;
        int diff;
        want = int'(expected);
        diff = int'(got) - want;
        if (diff > tol || diff < -tol)
            report_failure($sformatf("[FAIL] %0t: %s got %0d expected %0d",
                                     $time, name, got, want));
    endtask

    task automatic compare_flag(input string name, input logic got, input logic expected);
        if (got !== expected)
            report_failure($sformatf("[FAIL] %0t: %s got %b expected %b",
                                     $time, name, got, expected));
    endtask

    ////////////////////
    // Stimulus and model

    // One frame of samples with idle gaps of 1 to 3 cycles when asked
    task automatic queue_frame(input int fr_re[n], input int fr_im[n], input bit gaps);
        int gap_len;
        for (int i = 0; i < n; i++)
        begin
            if (gaps && $urandom_range(1, 0) == 1)
            begin
                gap_len = $urandom_range(3, 1);
                // Junk data on the bus while in_valid is low
                repeat (gap_len)
                begin
                    stim_valid.push_back(1'b0);
                    stim_re.push_back(random_sample(1 << (in_w - 1)));
                    stim_im.push_back(random_sample(1 << (in_w - 1)));
                end
            end
            stim_valid.push_back(1'b1);
            stim_re.push_back(fr_re[i]);
            stim_im.push_back(fr_im[i]);
        end
    endtask

    // Direct 16-point DFT queued in bit-reversed order
    task automatic queue_dft(input int fr_re[n], input int fr_im[n]);
        real acc_re;
        real acc_im;
        real angle;
        int  k;
        for (int m = 0; m < n; m++)
        begin
            k = bit_reverse(m);
            acc_re = 0.0;
            acc_im = 0.0;
            for (int t = 0; t < n; t++)
            begin
                angle = -2.0 * pi * real'(k * t) / real'(n);
                acc_re += real'(fr_re[t]) * $cos(angle) - real'(fr_im[t]) * $sin(angle);
                acc_im += real'(fr_re[t]) * $sin(angle) + real'(fr_im[t]) * $cos(angle);
            end
            exp_re.push_back(acc_re);
            exp_im.push_back(acc_im);
        end
    endtask

    // Impulse gives the same value in every bin
    task automatic queue_flat(input int amplitude);
        repeat (n)
        begin
            exp_re.push_back(real'(amplitude));
            exp_im.push_back(0.0);
        end
    endtask

    // Check the response to the last driven sample and drive the next one
    task automatic run_cycle(input int i);
        logic want_valid;
        @(negedge clk);
        // Primed once sample 16 has gone in
        want_valid = last_valid && (last_index >= n);
        compare_flag("out_valid", out_valid, want_valid);
        if (out_valid)
        begin
            if (exp_re.size() == 0)
                report_failure("out_valid was high with no expected bin left");
            else
            begin
                compare_bin("out_re", out_re, exp_re.pop_front());
                compare_bin("out_im", out_im, exp_im.pop_front());
            end
        end
        if (assertion_failures() != 0)
            report_failure("A butterfly delay line broke its FIFO occupancy rules");
        in_valid = stim_valid[i];
        in_re    = in_w'(stim_re[i]);
        in_im    = in_w'(stim_im[i]);
        last_valid = stim_valid[i];
        if (stim_valid[i])
        begin
            last_index = accepted;
            accepted++;
        end
    endtask

    ////////////////////
    // Cycle limit

    initial
    begin
        cycle_count = 0;
        forever
        begin
            @(posedge clk);
            cycle_count++;
            if (cycle_limit > 0 && cycle_count > cycle_limit)
                report_failure($sformatf("Timeout after %0d clock cycles", cycle_count));
        end
    end

    ////////////////////
    // Main sequence

    initial
    begin
        int frame_re [n];
        int frame_im [n];
        int zero_frame [n];
        rst_n      = 1'b1;
        in_valid   = 1'b0;
        in_re      = '0;
        in_im      = '0;
        last_valid = 1'b0;
        last_index = 0;
        accepted   = 0;
        void'($urandom(32'h8dcd1bcd));

        // Impulse frame gives a flat spectrum
        for (int i = 0; i < n; i++)
        begin
            frame_re[i]   = (i == 0) ? impulse_amp : 0;
            frame_im[i]   = 0;
            zero_frame[i] = 0;
        end
        queue_frame(frame_re, frame_im, 1'b0);
        queue_flat(impulse_amp);

        // Full-scale frames back to back
        repeat (burst_frames)
        begin
            for (int i = 0; i < n; i++)
            begin
                frame_re[i] = random_sample(1 << (in_w - 1));
                frame_im[i] = random_sample(1 << (in_w - 1));
            end
            queue_frame(frame_re, frame_im, 1'b0);
            queue_dft(frame_re, frame_im);
        end

        // Frames with idle gaps on in_valid
        repeat (gap_frames)
        begin
            for (int i = 0; i < n; i++)
            begin
                frame_re[i] = random_sample(1 << (in_w - 2));
                frame_im[i] = random_sample(1 << (in_w - 2));
            end
            queue_frame(frame_re, frame_im, 1'b1);
            queue_dft(frame_re, frame_im);
        end

        // Zero frame and one idle cycle push out the last data frame
        queue_frame(zero_frame, zero_frame, 1'b0);
        stim_valid.push_back(1'b0);
        stim_re.push_back(0);
        stim_im.push_back(0);

        cycle_limit = 2 * (stim_valid.size() + reset_cycles) + 100;

        repeat (reset_cycles)
            @(posedge clk);
        @(negedge clk);
        rst_n = 1'b0;

        for (int i = 0; i < stim_valid.size(); i++)
            run_cycle(i);

        if (exp_re.size() != 0 || assertion_failures() != 0)
            report_failure($sformatf("Run ended with %0d bins missing and %0d assertion failures",
                                     exp_re.size(), assertion_failures()));
        else
        begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule
